// File: verilog/aluPkg.sv
`default_nettype none

package aluPkg;

  ////////////////////////////////////////////////////////////
  // Major opcodes handled by the execute block
  ////////////////////////////////////////////////////////////
  localparam logic [6:0] opOp      = 7'b0110011; // Register-register
  localparam logic [6:0] opOpImm   = 7'b0010011; // Register-immediate
  localparam logic [6:0] opOp32    = 7'b0111011; // RV64 W forms
  localparam logic [6:0] opOpImm32 = 7'b0011011; // RV64 W immediates
  localparam logic [6:0] opBranch  = 7'b1100011; // Conditional branches

  // ALU result select, encoded to match funct3 of OP / OP-IMM
  typedef enum logic [2:0] {
    selAdd   = 3'b000, // add, sub
    selShift = 3'b001, // sll, srl, sra
    selSlt   = 3'b010,
    selSltu  = 3'b011,
    selXor   = 3'b100,
    selSrl   = 3'b101, // Free code routed to the shifter
    selOr    = 3'b110,
    selAnd   = 3'b111
  } aluSelT;

  // Branch funct3 codes
  localparam logic [2:0] brEq  = 3'b000;
  localparam logic [2:0] brNe  = 3'b001;
  localparam logic [2:0] brLt  = 3'b100;
  localparam logic [2:0] brGe  = 3'b101;
  localparam logic [2:0] brLtu = 3'b110;
  localparam logic [2:0] brGeu = 3'b111;

  ////////////////////////////////////////////////////////////
  // Instruction word layouts
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rTypeT;

  typedef struct packed {
    logic [11:0] imm;    // Also carries shamt and the shift tag
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } iTypeT;

  // Same 32 bits, read as R-type or I-type
  typedef union packed {
    rTypeT       r;
    iTypeT       i;
    logic [31:0] raw;
  } instrWordT;

endpackage

`default_nettype wire

// File: verilog/shifter.sv
`timescale 1ns/1ps
`default_nettype none

module shifter #(
  parameter int XLEN = 64
) (
  input  logic [XLEN-1:0]         a,
  input  logic [$clog2(XLEN)-1:0] amt,
  input  logic                    right, // 1 for srl / sra
  input  logic                    arith, // Sign fill on right shift
  input  logic                    w64,   // Word op on low 32 bits
  output logic [XLEN-1:0]         y
);

  localparam int AW = $clog2(XLEN);

  logic [XLEN-1:0]   opA;    // Operand after word prep
  logic [AW-1:0]     shAmt;  // Effective shift amount
  logic              fill;   // Bit shifted in from the top
  logic [2*XLEN-1:0] extA;
  logic [2*XLEN-1:0] shrOut;
  logic [XLEN-1:0]   shlOut;

  // Word ops see bit 31 as the top of the operand
  always_comb begin
    opA   = a;
    shAmt = amt;
    if (w64) begin
      for (int k = 32; k < XLEN; k++) begin
        opA[k] = arith & right & a[31]; // Sign or zero fill above bit 31
      end
      for (int k = 5; k < AW; k++) begin
        shAmt[k] = 1'b0;                // 5-bit amount only
      end
    end
  end

  assign fill   = arith & right & opA[XLEN-1];
  assign extA   = {{XLEN{fill}}, opA};         // Fill bits ride above the operand
  assign shrOut = extA >> shAmt;
  assign shlOut = opA << shAmt;

  assign y = right ? shrOut[XLEN-1:0] : shlOut; // Upper half of word result fixed in ALU

endmodule

`default_nettype wire

// File: verilog/branchCompare.sv
`timescale 1ns/1ps
`default_nettype none

module branchCompare #(
  parameter int XLEN = 64
) (
  input  logic [XLEN-1:0] a,
  input  logic [XLEN-1:0] b,
  input  logic [2:0]      funct3,
  output logic            condTrue
);

  logic eq;  // a == b
  logic lt;  // Signed a < b
  logic ltu; // Unsigned a < b

  // Independent of the ALU adder
  assign eq  = (a == b);
  assign lt  = ($signed(a) < $signed(b));
  assign ltu = (a < b);

  // Pick one relation and invert it for odd codes
  always_comb begin
    case (funct3)
      aluPkg::brEq:  condTrue = eq;
      aluPkg::brNe:  condTrue = ~eq;
      aluPkg::brLt:  condTrue = lt;
      aluPkg::brGe:  condTrue = ~lt;
      aluPkg::brLtu: condTrue = ltu;
      aluPkg::brGeu: condTrue = ~ltu;
      default:       condTrue = 1'b0; // Codes 2 and 3 never branch
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu #(
  parameter int XLEN = 64
) (
  input  logic [XLEN-1:0] a,
  input  logic [XLEN-1:0] b,
  input  logic            w64,       // RV64 W form
  input  logic            subArith,  // Subtract or arithmetic shift
  input  logic [2:0]      funct3,    // Bit 2 gives shift direction
  input  aluPkg::aluSelT  aluSelect,
  output logic [XLEN-1:0] result
);

  logic [XLEN-1:0] condMaskB;    // B mask equals plain B without bitmanip
  logic [XLEN-1:0] condShiftA;   // Shifted A equals plain A without bitmanip
  logic [XLEN-1:0] condMaskInvB; // B or ~B
  logic [XLEN-1:0] sum;
  logic [XLEN-1:0] shiftOut;
  logic [XLEN-1:0] fullResult;   // Before word sign extension
  logic            carry;
  logic            neg;
  logic            aSign;
  logic            bSign;
  logic            lt;
  logic            ltu;

  assign condMaskB  = b;
  assign condShiftA = a;

  ////////////////////////////////////////////////////////////
  // Adder / subtractor
  ////////////////////////////////////////////////////////////
  assign condMaskInvB = subArith ? ~condMaskB : condMaskB;
  assign {carry, sum} = {1'b0, condShiftA} + {1'b0, condMaskInvB}
                      + {{XLEN{1'b0}}, subArith}; // Carry-in completes two's complement

  shifter #(.XLEN(XLEN)) u_shifter (
    .a     (a),
    .amt   (b[$clog2(XLEN)-1:0]),
    .right (funct3[2]),
    .arith (subArith),
    .w64   (w64),
    .y     (shiftOut)
  );

  // Flags from a - b
  assign neg   = sum[XLEN-1];
  assign aSign = a[XLEN-1];
  assign bSign = b[XLEN-1];
  assign lt    = (aSign & ~bSign) | (aSign & neg) | (~bSign & neg); // Sign xor overflow
  assign ltu   = ~carry;                                            // Borrow out

  ////////////////////////////////////////////////////////////
  // Result select
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (aluSelect)
      aluPkg::selAdd:   fullResult = sum;
      aluPkg::selShift: fullResult = shiftOut;
      aluPkg::selSlt:   fullResult = {{(XLEN-1){1'b0}}, lt};
      aluPkg::selSltu:  fullResult = {{(XLEN-1){1'b0}}, ltu};
      aluPkg::selXor:   fullResult = a ^ condMaskInvB;
      aluPkg::selSrl:   fullResult = shiftOut;             // srl / sra by funct3 code
      aluPkg::selOr:    fullResult = a | condMaskInvB;
      aluPkg::selAnd:   fullResult = a & condMaskInvB;
      default:          fullResult = sum;
    endcase
  end

  // Word results keep only the low half
  if (XLEN == 64) begin : gWordExt
    assign result = w64 ? {{32{fullResult[31]}}, fullResult[31:0]} : fullResult;
  end else begin : gNoWordExt
    assign result = fullResult;
  end

endmodule

`default_nettype wire

// File: verilog/aluDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module aluDecoder #(
  parameter int XLEN = 64
) (
  input  aluPkg::instrWordT instr,
  input  logic [XLEN-1:0]   srcB,
  output aluPkg::aluSelT    aluSelect,
  output logic              subArith,
  output logic              w64,
  output logic [XLEN-1:0]   aluB,     // srcB or immediate
  output logic              isBranch,
  output logic              illegal
);

  localparam int          AW        = $clog2(XLEN);
  localparam logic [11:0] sraTag    = 12'h400 >> AW; // Upper imm bits of srai
  localparam logic [6:0]  funct7Alt = 7'b0100000;    // sub / sra marker

  logic [XLEN-1:0] immExt;    // Sign-extended I immediate
  logic [11:0]     immHi;     // Imm bits above the shift amount
  logic            f7Zero;
  logic            f7Alt;
  logic            sltCode;   // funct3 2 or 3
  logic            wFunctOk;  // funct3 0, 1 or 5
  logic            wImmOk;    // Upper imm of W shift immediates

  assign immExt   = {{(XLEN-12){instr.i.imm[11]}}, instr.i.imm};
  assign immHi    = instr.i.imm >> AW;
  assign f7Zero   = (instr.r.funct7 == 7'b0000000);
  assign f7Alt    = (instr.r.funct7 == funct7Alt);
  assign sltCode  = (instr.r.funct3[2:1] == 2'b01);
  assign wFunctOk = (instr.r.funct3 == 3'd0) || (instr.r.funct3 == 3'd1)
                  || (instr.r.funct3 == 3'd5);
  assign wImmOk   = (instr.i.imm[11:5] == 7'b0000000)
                  || ((instr.i.imm[11:5] == funct7Alt) && (instr.i.funct3 == 3'd5));

  always_comb begin
    aluSelect = aluPkg::aluSelT'(instr.r.funct3); // funct3 doubles as select
    subArith  = 1'b0;
    w64       = 1'b0;
    aluB      = srcB;
    isBranch  = 1'b0;
    illegal   = 1'b0;
    case (instr.r.opcode)
      aluPkg::opOp: begin
        subArith = instr.r.funct7[5] | sltCode; // sub, sra, slt, sltu
        illegal  = ~(f7Zero | (f7Alt & ((instr.r.funct3 == 3'd0) | (instr.r.funct3 == 3'd5))));
      end
      aluPkg::opOpImm: begin
        aluB     = immExt;
        subArith = sltCode | ((instr.i.funct3 == 3'd5) & instr.i.imm[10]); // srai, not addi
        if (instr.i.funct3 == 3'd1) begin
          illegal = (immHi != 12'd0);                          // slli
        end else if (instr.i.funct3 == 3'd5) begin
          illegal = !((immHi == 12'd0) || (immHi == sraTag)); // srli / srai
        end
      end
      aluPkg::opOp32: begin
        w64      = 1'b1;
        subArith = instr.r.funct7[5];                          // subw, sraw
        illegal  = (XLEN == 32) | ~wFunctOk
                 | ~(f7Zero | (f7Alt & (instr.r.funct3 != 3'd1)));
      end
      aluPkg::opOpImm32: begin
        w64      = 1'b1;
        aluB     = immExt;
        subArith = (instr.i.funct3 == 3'd5) & instr.i.imm[10]; // sraiw
        illegal  = (XLEN == 32) | ~wFunctOk | ((instr.i.funct3 != 3'd0) & ~wImmOk);
      end
      aluPkg::opBranch: begin
        aluSelect = aluPkg::selAdd; // Sum unused since the compare is separate
        subArith  = 1'b1;
        isBranch  = 1'b1;
        illegal   = sltCode;        // Codes 2 and 3 are reserved
      end
      default: illegal = 1'b1;      // Unknown opcode
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage #(
  parameter int XLEN = 64
) (
  input  logic              clk,
  input  logic              rstN,
  input  logic              instrValid,
  input  aluPkg::instrWordT instr,
  input  logic [XLEN-1:0]   srcA,
  input  logic [XLEN-1:0]   srcB,
  output logic              resultValid, // One cycle after instrValid
  output logic [XLEN-1:0]   result,
  output logic              branchTaken,
  output logic              illegal
);

  aluPkg::aluSelT  aluSelect;
  logic            subArith;
  logic            w64;
  logic [XLEN-1:0] aluB;
  logic            isBranch;
  logic            decIllegal;
  logic [XLEN-1:0] aluResult;
  logic            condTrue;

  aluDecoder #(.XLEN(XLEN)) u_aluDecoder (
    .instr     (instr),
    .srcB      (srcB),
    .aluSelect (aluSelect),
    .subArith  (subArith),
    .w64       (w64),
    .aluB      (aluB),
    .isBranch  (isBranch),
    .illegal   (decIllegal)
  );

  alu #(.XLEN(XLEN)) u_alu (
    .a         (srcA),
    .b         (aluB),
    .w64       (w64),
    .subArith  (subArith),
    .funct3    (instr.r.funct3),
    .aluSelect (aluSelect),
    .result    (aluResult)
  );

  // Compares register values, never the immediate
  branchCompare #(.XLEN(XLEN)) u_branchCompare (
    .a        (srcA),
    .b        (srcB),
    .funct3   (instr.r.funct3),
    .condTrue (condTrue)
  );

  ////////////////////////////////////////////////////////////
  // Output pipeline register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstN) begin
      resultValid <= 1'b0;
      branchTaken <= 1'b0;
      illegal     <= 1'b0;
    end else begin
      resultValid <= instrValid;  // Single-cycle pulse per instruction
      if (instrValid) begin
        branchTaken <= isBranch & condTrue;
        illegal     <= decIllegal;
      end
    end
  end

  // No writeback for branches or illegal ops
  always_ff @(posedge clk) begin
    if (instrValid) begin
      result <= (decIllegal | isBranch) ? '0 : aluResult;
    end
  end

endmodule

`default_nettype wire

// File: test/executeStage_properties.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage_properties (
  input logic clk,
  input logic rstN,
  input logic instrValid,
  input logic resultValid,
  input logic branchTaken,
  input logic illegal
);

  ////////////////////////////////////////////////////////////
  // Handshake timing
  ////////////////////////////////////////////////////////////
  // One pulse per accepted instruction, one cycle later
  validLatency: assert property (@(posedge clk) disable iff (!rstN)
    resultValid == $past(instrValid))
    else $error("resultValid does not follow instrValid by exactly one cycle");

  // Synchronous reset clears the flags on the next edge
  resetIdle: assert property (@(posedge clk)
    !rstN |=> (!resultValid && !branchTaken && !illegal))
    else $error("Outputs not idle during reset");

  ////////////////////////////////////////////////////////////
  // Output flags
  ////////////////////////////////////////////////////////////
  flagsExclusive: assert property (@(posedge clk) disable iff (!rstN)
    !(branchTaken && illegal))
    else $error("branchTaken and illegal both set"); // Illegal branch never taken

endmodule

bind executeStage executeStage_properties u_executeStageProperties (
  .clk         (clk),
  .rstN        (rstN),
  .instrValid  (instrValid),
  .resultValid (resultValid),
  .branchTaken (branchTaken),
  .illegal     (illegal)
);

`default_nettype wire

// File: test/executeStageTb.sv
`timescale 1ns/1ps
`default_nettype none

module executeStageTb;

  localparam int XLEN         = 64;
  localparam int maxVec       = 64;
  localparam int fieldsPerVec = 6;  // instr, srcA, srcB, result, taken, illegal
  localparam int burstLen     = 6;  // Tail of the list runs back to back
  localparam int resetCycles  = 10;

  logic              clk;
  logic              rstN;
  logic              instrValid;
  aluPkg::instrWordT instr;
  logic [XLEN-1:0]   srcA;
  logic [XLEN-1:0]   srcB;
  logic              resultValid;
  logic [XLEN-1:0]   result;
  logic              branchTaken;
  logic              illegal;

  logic [63:0]     vecMem [0:fieldsPerVec*maxVec-1]; // One word per column
  logic [XLEN-1:0] expResultQ[$];
  logic            expTakenQ[$];
  logic            expIllegalQ[$];
  int              expIndexQ[$];
  logic [XLEN-1:0] expResult;
  logic            expTaken;
  logic            expIllegal;
  int              expIdx;
  int              numVec       = 0;
  int              checkedCount = 0;
  int              cycleCount   = 0;
  int              cycleLimit   = 0; // Set once the vectors are counted

  executeStage #(.XLEN(XLEN)) u_executeStage (
    .clk         (clk),
    .rstN        (rstN),
    .instrValid  (instrValid),
    .instr       (instr),
    .srcA        (srcA),
    .srcB        (srcB),
    .resultValid (resultValid),
    .result      (result),
    .branchTaken (branchTaken),
    .illegal     (illegal)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk; // 40 ns period
  end

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////
  task automatic checkResult(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
      $display("Some tests failed");
      $fatal(1, "Result mismatch");
    end
  endtask

  task automatic checkFlag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
      $display("Some tests failed");
      $fatal(1, "Flag mismatch");
    end
  endtask

  // Outputs are stable at the falling edge
  always @(negedge clk) begin
    if (rstN && resultValid) begin
      if (expResultQ.size() == 0) begin
        $display("resultValid pulsed at %0t with no instruction in flight", $time);
        $display("Some tests failed");
        $fatal(1, "Unexpected resultValid");
      end else begin
        expIdx     = expIndexQ.pop_front();
        expResult  = expResultQ.pop_front();
        expTaken   = expTakenQ.pop_front();
        expIllegal = expIllegalQ.pop_front();
        checkResult(result, expResult, $sformatf("vector %0d result", expIdx));
        checkFlag(branchTaken, expTaken, $sformatf("vector %0d branchTaken", expIdx));
        checkFlag(illegal, expIllegal, $sformatf("vector %0d illegal", expIdx));
        checkedCount++;
      end
    end
  end

  // Watchdog on total cycles
  always @(posedge clk) begin
    cycleCount++;
    if (cycleLimit > 0 && cycleCount > cycleLimit) begin
      $display("Timeout after %0d cycles with %0d of %0d vectors checked",
               cycleCount, checkedCount, numVec);
      $display("Some tests failed");
      $fatal(1, "Timeout");
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////
  initial begin
    int gap;
    int base;
    void'($urandom(65)); // Seed the generator once
    rstN       = 1'b0;
    instrValid = 1'b0;
    instr      = '0;
    srcA       = '0;
    srcB       = '0;
    $readmemh("test/executeVectors.txt", vecMem);
    // Zero instruction word marks the end of the list
    while (numVec < maxVec && vecMem[numVec*fieldsPerVec][31:0] != 32'h0) begin
      numVec++;
    end
    if (numVec == 0) begin
      $display("No vectors were loaded from test/executeVectors.txt");
      $display("Some tests failed");
      $fatal(1, "Empty vector file");
    end
    cycleLimit = resetCycles + numVec * 5 + 20;

    repeat (resetCycles) @(negedge clk);
    rstN = 1'b1;

    for (int v = 0; v < numVec; v++) begin
      gap = (v < numVec - burstLen) ? int'($urandom % 4) : 0; // Idle 0 to 3 cycles
      repeat (gap) begin
        @(negedge clk);
        instrValid = 1'b0;
      end
      @(negedge clk);
      base       = v * fieldsPerVec;
      instr      = vecMem[base][31:0];
      srcA       = vecMem[base+1];
      srcB       = vecMem[base+2];
      instrValid = 1'b1;
      expResultQ.push_back(vecMem[base+3]);
      expTakenQ.push_back(vecMem[base+4][0]);
      expIllegalQ.push_back(vecMem[base+5][0]);
      expIndexQ.push_back(v);
    end
    @(negedge clk);
    instrValid = 1'b0;

    while (checkedCount < numVec) @(negedge clk);
    repeat (2) @(negedge clk); // A stray pulse here trips the checker
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: test/executeVectors.txt
// Columns: instr srcA srcB expResult expBranchTaken expIllegal, all hex
// A line with a zero instruction word ends the list
003100B3 7FFFFFFFFFFFFFFF 0000000000000001 8000000000000000 0 0
403100B3 0000000000000000 0000000000000001 FFFFFFFFFFFFFFFF 0 0
FFF10093 0000000000000010 123456789ABCDEF0 000000000000000F 0 0
003170B3 F0F0F0F0F0F0F0F0 FF00FF00FF00FF00 F000F000F000F000 0 0
003160B3 F0F0F0F0F0F0F0F0 FF00FF00FF00FF00 FFF0FFF0FFF0FFF0 0 0
003140B3 0123456789ABCDEF FFFFFFFFFFFFFFFF FEDCBA9876543210 0 0
55514093 0000000000000AAA 0000000000000000 0000000000000FFF 0 0
80017093 0123456789ABCDEF 0000000000000000 0123456789ABC800 0 0
003110B3 0000000000000001 00000000000000FF 8000000000000000 0 0
003150B3 8000000000000000 0000000000000044 0800000000000000 0 0
403150B3 8000000000000000 0000000000000004 F800000000000000 0 0
03F11093 0000000000000003 0000000000000000 8000000000000000 0 0
43C15093 8000000000000000 0000000000000000 FFFFFFFFFFFFFFF8 0 0
003120B3 8000000000000000 7FFFFFFFFFFFFFFF 0000000000000001 0 0
003130B3 8000000000000000 7FFFFFFFFFFFFFFF 0000000000000000 0 0
003120B3 7FFFFFFFFFFFFFFF 8000000000000000 0000000000000000 0 0
003130B3 0000000000000000 FFFFFFFFFFFFFFFF 0000000000000001 0 0
FFF12093 8000000000000000 0000000000000000 0000000000000001 0 0
FFF13093 FFFFFFFFFFFFFFFE 0000000000000000 0000000000000001 0 0
003100BB 000000007FFFFFFF 0000000000000001 FFFFFFFF80000000 0 0
403100BB 1234567800000005 0000000000000003 0000000000000002 0 0
003110BB 0000000000000001 000000000000003F FFFFFFFF80000000 0 0
003150BB FFFFFFFF80000000 0000000000000004 0000000008000000 0 0
403150BB 0000000080000000 0000000000000024 FFFFFFFFF8000000 0 0
00310063 0000000000000005 0000000000000005 0000000000000000 1 0
00311063 0000000000000005 0000000000000005 0000000000000000 0 0
00314063 FFFFFFFFFFFFFFFF 0000000000000001 0000000000000000 1 0
00315063 FFFFFFFFFFFFFFFF 0000000000000001 0000000000000000 0 0
00316063 FFFFFFFFFFFFFFFF 0000000000000001 0000000000000000 0 0
00317063 FFFFFFFFFFFFFFFF 0000000000000001 0000000000000000 1 0
0031007F 1111111111111111 2222222222222222 0000000000000000 0 1
023100B3 1111111111111111 2222222222222222 0000000000000000 0 1
00312063 0000000000000000 0000000000000000 0000000000000000 0 1
00313063 0000000000000003 0000000000000003 0000000000000000 0 1
00000000 0 0 0 0 0

// File: files.f
verilog/aluPkg.sv
verilog/shifter.sv
verilog/branchCompare.sv
verilog/alu.sv
verilog/aluDecoder.sv
verilog/executeStage.sv
test/executeStage_properties.sv
test/executeStageTb.sv

// File: run.sh
#!/bin/sh
set -e

# Build with assertions enabled, then run from the project root
verilator --binary --timing --assert -Wno-fatal --top-module executeStageTb -f files.f

out=$(./obj_dir/VexecuteStageTb) || true
echo "$out"

if echo "$out" | grep -qF "All tests passed"; then
  exit 0
else
  exit 1
fi
